//--- src/ex_pkg.sv
////////////////////////////////////////////////////////////
// Shared widths, opcodes and port structs of the EX stage
// Operand order in the structs is a, b, c as seen by the ALU
////////////////////////////////////////////////////////////

`default_nettype none

package ex_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  localparam int XLEN       = 32;             // Data word width
  localparam int REG_ADDR_W = 6;              // Room for the FP register file later
  localparam int SHAMT_W    = $clog2(XLEN);   // Shift amount bits taken from operand b

  // Iterative high-half multiply
  localparam int MUL_STEPS   = 4;                        // One quarter of operand b per step
  localparam int MUL_SLICE_W = XLEN / MUL_STEPS;         // Bits of b per step
  localparam int MUL_CNT_W   = $clog2(MUL_STEPS + 1);    // Step counter, counts up to MUL_STEPS
  localparam int MUL_PART_W  = XLEN + MUL_SLICE_W + 2;   // 33-bit a times signed slice

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  ////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////

  // ALU operator, spare codes are illegal
  typedef enum logic [4:0] {
    ALU_ADD  = 5'h00,
    ALU_SUB  = 5'h01,
    ALU_AND  = 5'h02,
    ALU_OR   = 5'h03,
    ALU_XOR  = 5'h04,
    ALU_SLL  = 5'h05,
    ALU_SRL  = 5'h06,
    ALU_SRA  = 5'h07,
    ALU_SLT  = 5'h08,  // Signed set-less-than
    ALU_SLTU = 5'h09,  // Unsigned set-less-than
    ALU_EQ   = 5'h0c,  // Branch compares from here on
    ALU_NE   = 5'h0d,
    ALU_LT   = 5'h10,
    ALU_GE   = 5'h11,
    ALU_LTU  = 5'h12,
    ALU_GEU  = 5'h13
  } alu_op_e;

  // Multiplier operator
  typedef enum logic [1:0] {
    MUL_MUL    = 2'b00,  // Low half, single cycle
    MUL_MULH   = 2'b01,  // High half, signed x signed
    MUL_MULHSU = 2'b10,  // High half, signed x unsigned
    MUL_MULHU  = 2'b11   // High half, unsigned x unsigned
  } mul_op_e;

  ////////////////////////////////////////////////////////////
  // Request and write-port bundles
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic    en;
    alu_op_e op;
    word_t   a;
    word_t   b;
    word_t   c;   // Jump target, passed through
  } alu_req_t;

  typedef struct packed {
    logic    en;
    mul_op_e op;
    word_t   a;
    word_t   b;
  } mul_req_t;

  // One register-file write
  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    word_t     data;
  } rf_wr_t;

endpackage

`default_nettype wire

//--- src/ex_alu.sv
////////////////////////////////////////////////////////////
// Purely combinational, always ready, no division
// Shift amount is the low SHAMT_W bits of operand b
////////////////////////////////////////////////////////////

`default_nettype none

module ex_alu import ex_pkg::*; (
  input  alu_req_t alu_req_i,
  output word_t    result_o,
  output logic     cmp_o      // Branch decision or SLT bit
);

  logic            is_sub;      // Adder subtracts
  logic            is_signed;   // Signed compare, extends operands
  logic [XLEN:0]   adder_a;
  logic [XLEN:0]   adder_b;
  logic [XLEN:0]   adder_sum;   // Bit XLEN is the less-than flag
  logic            less;

  logic            shift_left;
  logic            shift_arith;
  logic [SHAMT_W-1:0] shamt;
  word_t           a_rev;       // Operand a bit-reversed for left shifts
  word_t           shift_in;
  logic [XLEN:0]   shift_wide;  // Extra top bit carries the fill
  word_t           shift_right;
  word_t           shift_rev;

  ////////////////////////////////////////////////////////////
  // Adder
  ////////////////////////////////////////////////////////////

  assign is_sub    = alu_req_i.op inside {ALU_SUB, ALU_SLT, ALU_SLTU,
                                          ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};
  assign is_signed = alu_req_i.op inside {ALU_SLT, ALU_LT, ALU_GE};

  // 33-bit operands so one subtract serves both signed and unsigned compares
  assign adder_a = {is_signed & alu_req_i.a[XLEN-1], alu_req_i.a};
  assign adder_b = {is_signed & alu_req_i.b[XLEN-1], alu_req_i.b};

  assign adder_sum = adder_a + (is_sub ? ~adder_b : adder_b) + {{XLEN{1'b0}}, is_sub};
  assign less      = adder_sum[XLEN];   // Sign of a - b

  ////////////////////////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////////////////////////

  assign shift_left  = (alu_req_i.op == ALU_SLL);
  assign shift_arith = (alu_req_i.op == ALU_SRA);
  assign shamt       = alu_req_i.b[SHAMT_W-1:0];

  // Left shift is a right shift of the reversed word
  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      a_rev[i]     = alu_req_i.a[XLEN-1-i];
      shift_rev[i] = shift_right[XLEN-1-i];
    end
  end

  assign shift_in    = shift_left ? a_rev : alu_req_i.a;
  assign shift_wide  = $signed({shift_arith & shift_in[XLEN-1], shift_in}) >>> shamt;
  assign shift_right = shift_wide[XLEN-1:0];

  ////////////////////////////////////////////////////////////
  // Compare and result select
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique case (alu_req_i.op)
      ALU_EQ:                          cmp_o = (alu_req_i.a == alu_req_i.b);
      ALU_NE:                          cmp_o = (alu_req_i.a != alu_req_i.b);
      ALU_LT, ALU_LTU, ALU_SLT, ALU_SLTU: cmp_o = less;
      ALU_GE, ALU_GEU:                 cmp_o = ~less;
      default:                         cmp_o = 1'b0;  // Not a compare
    endcase
  end

  always_comb begin
    unique case (alu_req_i.op)
      ALU_ADD, ALU_SUB: result_o = adder_sum[XLEN-1:0];
      ALU_AND:          result_o = alu_req_i.a & alu_req_i.b;
      ALU_OR:           result_o = alu_req_i.a | alu_req_i.b;
      ALU_XOR:          result_o = alu_req_i.a ^ alu_req_i.b;
      ALU_SLL:          result_o = shift_rev;
      ALU_SRL, ALU_SRA: result_o = shift_right;
      ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE,
      ALU_LT, ALU_GE, ALU_LTU, ALU_GEU:
        result_o = {{(XLEN-1){1'b0}}, cmp_o};    // Compare bit, zero-extended
      default:          result_o = '0;
    endcase
  end

  // An enabled request carries a defined operator
  op_known_a: assert final (!alu_req_i.en || alu_req_i.op inside {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
      ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU})
    else $error("ex_alu: illegal operator %0h", alu_req_i.op);

endmodule

`default_nettype wire

//--- src/ex_mult.sv
////////////////////////////////////////////////////////////
// MUL in one cycle, MULH* in MUL_STEPS extra cycles
// Operands must stay steady until ready_o and ex_ready_i
////////////////////////////////////////////////////////////

`default_nettype none

module ex_mult import ex_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  mul_req_t mul_req_i,
  input  logic     ex_ready_i,     // Stage hands the result on
  output word_t    result_o,
  output logic     ready_o,
  output logic     multicycle_o    // High-half product in progress
);

  typedef enum logic [1:0] {
    MUL_IDLE,
    MUL_BUSY,   // Accumulating slices
    MUL_DONE    // High half ready, waiting on the stage
  } mul_state_e;

  mul_state_e               state_q;
  logic [MUL_CNT_W-1:0]     cnt_q;       // Slices already accumulated
  logic [2*XLEN-1:0]        acc_q;       // Product modulo 2^64
  logic                     hi_start;
  logic                     a_signed;
  logic                     b_signed;
  logic [MUL_CNT_W-1:0]     slice_idx;
  logic                     last_slice;
  logic signed [XLEN:0]     op_a_ext;
  logic [XLEN:0]            op_b_ext;
  logic signed [MUL_SLICE_W:0] b_slice;  // Signed on the top slice only
  logic signed [MUL_PART_W-1:0] part;
  logic [2*XLEN-1:0]        part_sh;     // Partial product at its weight
  word_t                    prod_lo;

  ////////////////////////////////////////////////////////////
  // Operand extension and one slice product
  ////////////////////////////////////////////////////////////

  assign hi_start = mul_req_i.en && (mul_req_i.op != MUL_MUL) && (state_q == MUL_IDLE);
  assign a_signed = mul_req_i.op inside {MUL_MULH, MUL_MULHSU};
  assign b_signed = (mul_req_i.op == MUL_MULH);

  assign op_a_ext = {a_signed & mul_req_i.a[XLEN-1], mul_req_i.a};
  assign op_b_ext = {b_signed & mul_req_i.b[XLEN-1], mul_req_i.b};

  assign slice_idx  = (state_q == MUL_BUSY) ? cnt_q : '0;   // Slice 0 in the start cycle
  assign last_slice = (slice_idx == MUL_CNT_W'(MUL_STEPS - 1));
  assign b_slice    = {last_slice & op_b_ext[XLEN],
                       op_b_ext[slice_idx*MUL_SLICE_W +: MUL_SLICE_W]};

  assign part    = op_a_ext * b_slice;
  assign part_sh = {{(2*XLEN-MUL_PART_W){part[MUL_PART_W-1]}}, part}
                   << (slice_idx * MUL_SLICE_W);

  assign prod_lo = mul_req_i.a * mul_req_i.b;   // MUL path

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MUL_IDLE;
      cnt_q   <= '0;
    end else begin
      unique case (state_q)
        MUL_IDLE: begin
          if (hi_start) begin
            state_q <= MUL_BUSY;
            cnt_q   <= MUL_CNT_W'(1);
          end
        end
        MUL_BUSY: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == MUL_CNT_W'(MUL_STEPS - 1)) state_q <= MUL_DONE;
        end
        MUL_DONE: begin
          if (ex_ready_i) begin   // Result taken
            state_q <= MUL_IDLE;
            cnt_q   <= '0;
          end
        end
        default: state_q <= MUL_IDLE;
      endcase
    end
  end

  // Accumulator
  always_ff @(posedge clk) begin
    if (hi_start) acc_q <= part_sh;                        // First slice
    else if (state_q == MUL_BUSY) acc_q <= acc_q + part_sh;
  end

  assign result_o     = (state_q == MUL_DONE) ? acc_q[2*XLEN-1:XLEN] : prod_lo;
  assign ready_o      = (state_q == MUL_DONE) || ((state_q == MUL_IDLE) && !hi_start);
  assign multicycle_o = hi_start || (state_q == MUL_BUSY);

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Upstream holds the request for the whole iteration
  req_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
      (state_q != MUL_IDLE) |->
        ($stable(mul_req_i.op) && $stable(mul_req_i.a) && $stable(mul_req_i.b)))
    else $error("ex_mult: request changed while busy");

  step_bound_a: assert property (@(posedge clk) disable iff (!rst_n)
      (cnt_q <= MUL_CNT_W'(MUL_STEPS)))
    else $error("ex_mult: step count %0d beyond limit", cnt_q);

endmodule

`default_nettype wire

//--- src/ex_wb_ports.sv
////////////////////////////////////////////////////////////
// Forward port is combinational, LSU port is one cycle late
// At most one of ALU, multiplier and CSR drives per cycle
////////////////////////////////////////////////////////////

`default_nettype none

module ex_wb_ports import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  word_t     alu_result_i,
  input  word_t     mult_result_i,
  input  word_t     csr_rdata_i,
  input  logic      alu_en_i,
  input  logic      mult_en_i,
  input  logic      csr_access_i,
  input  logic      alu_we_i,
  input  logic      regfile_we_i,
  input  reg_addr_t alu_waddr_i,
  input  reg_addr_t regfile_waddr_i,
  input  word_t     lsu_rdata_i,
  input  logic      lsu_err_i,
  input  logic      ex_valid_i,
  input  logic      wb_ready_i,    // WB can take a new entry
  output rf_wr_t    fw_wr_o,       // ALU/forward write port
  output rf_wr_t    wb_wr_o        // LSU write port
);

  logic      lsu_we_q;     // EX/WB write enable
  reg_addr_t lsu_waddr_q;  // EX/WB destination
  logic      lsu_we_d;

  ////////////////////////////////////////////////////////////
  // Forward port
  ////////////////////////////////////////////////////////////

  always_comb begin
    fw_wr_o.we   = alu_we_i;
    fw_wr_o.addr = alu_waddr_i;
    fw_wr_o.data = '0;
    if (csr_access_i) fw_wr_o.data = csr_rdata_i;      // CSR wins
    else if (mult_en_i) fw_wr_o.data = mult_result_i;
    else if (alu_en_i) fw_wr_o.data = alu_result_i;
  end

  ////////////////////////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////////////////////////

  assign lsu_we_d = regfile_we_i & ~lsu_err_i;   // Faulting loads never write

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q    <= 1'b0;
      lsu_waddr_q <= '0;
    end else if (ex_valid_i) begin   // WB ready is implied
      lsu_we_q <= lsu_we_d;
      if (lsu_we_d) lsu_waddr_q <= regfile_waddr_i;
    end else if (wb_ready_i) begin
      lsu_we_q <= 1'b0;              // Nothing new, flush the entry
    end
  end

  // Load data arrives from the LSU in the WB cycle
  assign wb_wr_o.we   = lsu_we_q;
  assign wb_wr_o.addr = lsu_waddr_q;
  assign wb_wr_o.data = lsu_rdata_i;

  // Result sources are exclusive
  one_src_a: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({alu_en_i, mult_en_i, csr_access_i}))
    else $error("ex_wb_ports: more than one result source enabled");

endmodule

`default_nettype wire

//--- src/ex_stage.sv
////////////////////////////////////////////////////////////
// EX stage top, ALU plus multiplier, no division or FPU
// Inputs must hold while ex_ready_o is low
////////////////////////////////////////////////////////////

`default_nettype none

module ex_stage import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,

  // Requests from ID
  input  alu_req_t  alu_req_i,
  input  mul_req_t  mul_req_i,
  input  logic      csr_access_i,
  input  word_t     csr_rdata_i,

  // Destinations
  input  logic      alu_we_i,         // Forward port
  input  reg_addr_t alu_waddr_i,
  input  logic      regfile_we_i,     // LSU port, written in WB
  input  reg_addr_t regfile_waddr_i,

  // LSU
  input  logic      lsu_en_i,
  input  word_t     lsu_rdata_i,
  input  logic      lsu_ready_ex_i,   // EX part of the access done
  input  logic      lsu_err_i,

  input  logic      branch_in_ex_i,
  input  logic      wb_ready_i,

  output rf_wr_t    fw_wr_o,
  output rf_wr_t    wb_wr_o,
  output logic      branch_decision_o,
  output word_t     jump_target_o,
  output logic      mult_multicycle_o,
  output logic      ex_ready_o,
  output logic      ex_valid_o
);

  word_t alu_result;
  logic  alu_cmp;
  word_t mult_result;
  logic  mult_ready;
  logic  units_ready;   // Multiplier, LSU and WB all free

  ex_alu i_alu (
    .alu_req_i (alu_req_i),
    .result_o  (alu_result),
    .cmp_o     (alu_cmp)
  );

  ex_mult i_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .mul_req_i    (mul_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////

  assign units_ready = mult_ready & lsu_ready_ex_i & wb_ready_i;

  // Valid never looks at ready, branches retire without WB
  assign ex_valid_o = (alu_req_i.en | mul_req_i.en | csr_access_i | lsu_en_i) & units_ready;
  assign ex_ready_o = units_ready | branch_in_ex_i;

  assign branch_decision_o = alu_cmp;
  assign jump_target_o     = alu_req_i.c;   // Target computed in ID

  ex_wb_ports i_wb_ports (
    .clk             (clk),
    .rst_n           (rst_n),
    .alu_result_i    (alu_result),
    .mult_result_i   (mult_result),
    .csr_rdata_i     (csr_rdata_i),
    .alu_en_i        (alu_req_i.en),
    .mult_en_i       (mul_req_i.en),
    .csr_access_i    (csr_access_i),
    .alu_we_i        (alu_we_i),
    .regfile_we_i    (regfile_we_i),
    .alu_waddr_i     (alu_waddr_i),
    .regfile_waddr_i (regfile_waddr_i),
    .lsu_rdata_i     (lsu_rdata_i),
    .lsu_err_i       (lsu_err_i),
    .ex_valid_i      (ex_valid_o),
    .wb_ready_i      (wb_ready_i),
    .fw_wr_o         (fw_wr_o),
    .wb_wr_o         (wb_wr_o)
  );

  // No result leaves while a high-half product iterates
  no_valid_busy_a: assert property (@(posedge clk) disable iff (!rst_n)
      mult_multicycle_o |-> !ex_valid_o)
    else $error("ex_stage: ex_valid while multiplier busy");

endmodule

`default_nettype wire

//--- bench/tb_ex_stage.sv
////////////////////////////////////////////////////////////
// Bench for ex_stage; checks live in concurrent assertions
// Multiplies run with WB and LSU ready, latency is checked
////////////////////////////////////////////////////////////

`default_nettype none

module tb_ex_stage import ex_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  logic        clk = 1'b0;
  logic        rst_n;
  alu_req_t    alu_req;
  mul_req_t    mul_req;
  logic        csr_access, alu_we, regfile_we, lsu_en, lsu_ready_ex, lsu_err;
  logic        branch_in_ex, wb_ready;
  word_t       csr_rdata, lsu_rdata;
  reg_addr_t   alu_waddr, regfile_waddr;
  rf_wr_t      fw_wr, wb_wr;
  logic        branch_decision, mult_multicycle, ex_ready, ex_valid;
  word_t       jump_target;
  int unsigned accept_cnt;                    // Edges with ex_valid high
  integer      seed;

  always #20 clk = ~clk;                      // 40 ns period

  ex_stage i_dut (
    .clk (clk), .rst_n (rst_n),
    .alu_req_i (alu_req), .mul_req_i (mul_req),
    .csr_access_i (csr_access), .csr_rdata_i (csr_rdata),
    .alu_we_i (alu_we), .alu_waddr_i (alu_waddr),
    .regfile_we_i (regfile_we), .regfile_waddr_i (regfile_waddr),
    .lsu_en_i (lsu_en), .lsu_rdata_i (lsu_rdata),
    .lsu_ready_ex_i (lsu_ready_ex), .lsu_err_i (lsu_err),
    .branch_in_ex_i (branch_in_ex), .wb_ready_i (wb_ready),
    .fw_wr_o (fw_wr), .wb_wr_o (wb_wr),
    .branch_decision_o (branch_decision), .jump_target_o (jump_target),
    .mult_multicycle_o (mult_multicycle), .ex_ready_o (ex_ready), .ex_valid_o (ex_valid)
  );

  // Counted on the rising edge, read by the stimulus on the falling one
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) accept_cnt <= 0;
    else if (ex_valid) accept_cnt <= accept_cnt + 1;
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic logic cmp_ref(alu_op_e op, word_t a, word_t b);
    case (op)
      ALU_EQ:           return a == b;
      ALU_NE:           return a != b;
      ALU_SLT, ALU_LT:  return $signed(a) < $signed(b);
      ALU_SLTU, ALU_LTU: return a < b;
      ALU_GE:           return !($signed(a) < $signed(b));
      ALU_GEU:          return !(a < b);
      default:          return 1'b0;
    endcase
  endfunction

  function automatic word_t alu_ref(alu_op_e op, word_t a, word_t b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      ALU_SRA: return $signed(a) >>> b[4:0];
      default: return {31'b0, cmp_ref(op, a, b)};   // Compares give one bit
    endcase
  endfunction

  function automatic word_t mul_ref(mul_op_e op, word_t a, word_t b);
    logic signed [65:0] ea;
    logic signed [65:0] eb;
    logic signed [65:0] prod;
    ea   = {{34{(op == MUL_MULH || op == MUL_MULHSU) & a[31]}}, a};
    eb   = {{34{(op == MUL_MULH) & b[31]}}, b};
    prod = ea * eb;
    return (op == MUL_MUL) ? prod[31:0] : prod[63:32];
  endfunction

  ////////////////////////////////////////////////////////////
  // Failure handling
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_error(input string msg);
    abort_run($sformatf("error at %0t ns: %s", $time, msg));
  endtask

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  alu_result_a: assert property (@(posedge clk) disable iff (!rst_n)
      ex_valid && alu_req.en |-> fw_wr.data == alu_ref(alu_req.op, alu_req.a, alu_req.b)
        && fw_wr.we == alu_we && fw_wr.addr == alu_waddr)
    else report_error($sformatf("ALU %s result %h", alu_req.op.name(), fw_wr.data));

  branch_a: assert property (@(posedge clk) disable iff (!rst_n)
      alu_req.en |-> branch_decision == cmp_ref(alu_req.op, alu_req.a, alu_req.b)
        && jump_target == alu_req.c)
    else report_error($sformatf("branch outputs wrong for %s", alu_req.op.name()));

  branch_ready_a: assert property (@(posedge clk) disable iff (!rst_n)
      branch_in_ex |-> ex_ready)
    else report_error("ex_ready low with a branch in EX");

  alu_valid_a: assert property (@(posedge clk) disable iff (!rst_n)
      (alu_req.en || csr_access) && wb_ready && lsu_ready_ex |-> ex_valid)
    else report_error("ex_valid missing for a combinational request");

  mul_result_a: assert property (@(posedge clk) disable iff (!rst_n)
      ex_valid && mul_req.en |-> fw_wr.data == mul_ref(mul_req.op, mul_req.a, mul_req.b))
    else report_error($sformatf("%s result %h", mul_req.op.name(), fw_wr.data));

  mul_wait_a: assert property (@(posedge clk) disable iff (!rst_n)
      mul_req.en && mul_req.op != MUL_MUL && !ex_valid && wb_ready && lsu_ready_ex
        && !branch_in_ex |-> mult_multicycle && !ex_ready)
    else report_error("high-half multiply not held busy");

  mul_latency_a: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(mult_multicycle) && wb_ready && lsu_ready_ex |-> ##MUL_STEPS ex_valid)
    else report_error("high-half multiply latency wrong");

  csr_a: assert property (@(posedge clk) disable iff (!rst_n)
      ex_valid && csr_access |-> fw_wr.data == csr_rdata)
    else report_error("CSR data not on forward port");

  lsu_write_a: assert property (@(posedge clk) disable iff (!rst_n)
      ex_valid && regfile_we && !lsu_err |=> wb_wr.we
        && wb_wr.addr == $past(regfile_waddr) && wb_wr.data == lsu_rdata)
    else report_error("LSU write-back missing or wrong");

  lsu_err_a: assert property (@(posedge clk) disable iff (!rst_n)
      ex_valid && lsu_err |=> !wb_wr.we)
    else report_error("faulting load wrote the register file");

  stall_a: assert property (@(posedge clk) disable iff (!rst_n)
      !(wb_ready && lsu_ready_ex) |-> !ex_valid && (branch_in_ex || !ex_ready))
    else report_error("handshake active under back-pressure");

  wb_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
      !wb_ready |=> $stable(wb_wr.we) && $stable(wb_wr.addr))
    else report_error("EX/WB register changed while WB stalled");

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic idle_inputs();
    alu_req = '{en: 1'b0, op: ALU_ADD, a: '0, b: '0, c: '0};
    mul_req = '{en: 1'b0, op: MUL_MUL, a: '0, b: '0};
    csr_access = 1'b0;  csr_rdata = '0;
    alu_we = 1'b0;      alu_waddr = '0;
    regfile_we = 1'b0;  regfile_waddr = '0;
    lsu_en = 1'b0;      lsu_rdata = '0;
    lsu_err = 1'b0;     lsu_ready_ex = 1'b1;
    branch_in_ex = 1'b0;
    wb_ready = 1'b1;
  endtask

  // Returns on the falling edge after the accepting edge
  task automatic wait_accept(input string what);
    int unsigned start;
    logic        done;
    start = accept_cnt;
    done  = 1'b0;
    for (int n = 0; n < 4 * MUL_STEPS && !done; n++) begin
      @(negedge clk);
      done = (accept_cnt != start);
    end
    if (!done) abort_run($sformatf("timeout waiting for ex_valid on %s", what));
  endtask

  task automatic run_alu(input alu_op_e op, input word_t a, input word_t b);
    idle_inputs();
    alu_req   = '{en: 1'b1, op: op, a: a, b: b, c: $random(seed)};
    alu_we    = $random(seed);                  // Both write-enable values reach the port
    alu_waddr = $random(seed);
    wait_accept(op.name());
  endtask

  task automatic run_mul(input mul_op_e op, input word_t a, input word_t b);
    idle_inputs();
    mul_req = '{en: 1'b1, op: op, a: a, b: b};
    alu_we  = 1'b1;
    wait_accept(op.name());
  endtask

  task automatic run_lsu(input logic err, input int stall);
    idle_inputs();
    lsu_en        = 1'b1;
    regfile_we    = 1'b1;
    regfile_waddr = $random(seed);
    lsu_rdata     = $random(seed);
    lsu_err       = err;
    lsu_ready_ex  = (stall == 0);
    repeat (stall) @(negedge clk);               // LSU still busy
    lsu_ready_ex  = 1'b1;
    wait_accept("LSU access");
  endtask

  initial begin
    alu_op_e op;
    mul_op_e mop;
    word_t   a, b;
    seed  = 32'h7f7e4bb4;
    rst_n = 1'b0;
    idle_inputs();
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    reset_state_a: assert (!wb_wr.we && !mult_multicycle && ex_ready)
      else abort_run("state after reset is wrong");

    op = op.first();                            // Every ALU operator
    repeat (op.num()) begin
      for (int r = 0; r < 5; r++) begin
        a = (r == 1) ? 32'h8000_0000 : $random(seed);
        b = (r == 0) ? a : $random(seed);      // Equal operands for EQ/GE
        run_alu(op, a, b);
      end
      op = op.next();
    end

    mop = mop.first();                          // Back-to-back multiplies
    repeat (mop.num()) begin
      run_mul(mop, 32'h8000_0000, 32'h8000_0000);
      run_mul(mop, 32'hffff_ffff, 32'hffff_ffff);
      for (int r = 0; r < 4; r++) run_mul(mop, $random(seed), $random(seed));
      mop = mop.next();
    end

    for (int r = 0; r < 3; r++) begin
      idle_inputs();
      csr_access = 1'b1;
      csr_rdata  = $random(seed);
      alu_we     = 1'b1;
      wait_accept("CSR read");
    end

    run_lsu(1'b0, 0);
    run_lsu(1'b1, 0);                           // Faulting load
    run_lsu(1'b0, 2);

    // Compare in EX with WB stalled, ready must stay high
    idle_inputs();
    alu_req      = '{en: 1'b1, op: ALU_LT, a: $random(seed), b: $random(seed), c: 32'h400};
    branch_in_ex = 1'b1;
    wb_ready     = 1'b0;
    repeat (3) @(negedge clk);
    wb_ready     = 1'b1;
    wait_accept("branch compare");

    // WB stall with a live write pending in EX/WB
    run_lsu(1'b0, 0);
    idle_inputs();
    alu_req  = '{en: 1'b1, op: ALU_SUB, a: $random(seed), b: $random(seed), c: '0};
    wb_ready = 1'b0;
    repeat (4) @(negedge clk);
    wb_ready = 1'b1;
    wait_accept("stalled ALU request");

    idle_inputs();
    repeat (2) @(negedge clk);
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
src/ex_pkg.sv
src/ex_alu.sv
src/ex_mult.sv
src/ex_wb_ports.sv
src/ex_stage.sv
bench/tb_ex_stage.sv

//--- Bender.yml
package:
  name: ex_stage

sources:
  - src/ex_pkg.sv
  - src/ex_alu.sv
  - src/ex_mult.sv
  - src/ex_wb_ports.sv
  - src/ex_stage.sv
  - target: simulation
    files:
      - bench/tb_ex_stage.sv
